// ==== hw/msi_buf_pkg.sv ====
package msi_buf_pkg;

  localparam int lane_width        = 32;  // line bits held by one lane ram.
  localparam int lane_count        = 16;
  localparam int line_width        = 512;
  localparam int entry_count       = 32;
  localparam int entry_addr_width  = 5;
  localparam int count_width       = 6;   // counts 0 to 32 entries.
  localparam int almost_full_level = 24;

  typedef logic [line_width-1:0]       line_t;
  typedef logic [entry_addr_width-1:0] entry_addr_t;
  typedef logic [count_width-1:0]      entry_count_t;

  // bit 2k holds bank 0, bit 2k+1 holds bank 1.
  typedef logic [2*lane_width-1:0]     lane_word_t;

  typedef struct packed {
    entry_addr_t addr;
    logic        bank;
    line_t       data;
  } store_wr_t;

  typedef enum logic [0:0] {
    rx_idle,
    rx_ack   // in_ack high, waiting for in_req to drop.
  } rx_state_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_read,
    tx_load0,
    tx_send0,
    tx_wait0,
    tx_send1,
    tx_wait1
  } tx_state_t;

endpackage

// ==== hw/msi_data_ram.sv ====
`timescale 1ns/1ps

module msi_data_ram (
  input  logic                    clk,
  input  msi_buf_pkg::entry_addr_t rd_addr,
  input  logic                    rd_en,
  output msi_buf_pkg::lane_word_t  rd_data,
  input  msi_buf_pkg::entry_addr_t wr_addr,
  input  msi_buf_pkg::lane_word_t  wr_data,
  input  msi_buf_pkg::lane_word_t  wr_ben,
  input  logic                    wr_en
);
  import msi_buf_pkg::*;

  lane_word_t  mem [entry_count];
  entry_addr_t rd_addr_q;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
    if (wr_en) begin
      for (int b = 0; b < 2*lane_width; b++) begin
        if (wr_ben[b]) begin
          mem[wr_addr][b] <= wr_data[b];  // only the masked bank changes.
        end
      end
    end
  end

  assign rd_data = mem[rd_addr_q];  // async read from the latched address.

endmodule

// ==== hw/msi_line_store.sv ====
`timescale 1ns/1ps

module msi_line_store (
  input  logic                   clk,
  input  logic                   arst_n,
  input  msi_buf_pkg::store_wr_t wr,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  logic                   rd_bank,
  output msi_buf_pkg::line_t     rd_line,
  output logic                   entry_ready,
  output logic                   almost_full
);
  import msi_buf_pkg::*;

  entry_addr_t  rd_ptr;
  entry_count_t count;
  lane_word_t   wr_ben;
  lane_word_t   rd_word [lane_count];
  logic         entry_done;

  // each line bit is copied into both positions of its pair.
  function automatic lane_word_t spread(input logic [lane_width-1:0] bits);
    lane_word_t word;
    for (int b = 0; b < lane_width; b++) begin
      word[2*b +: 2] = {2{bits[b]}};
    end
    return word;
  endfunction

  function automatic logic [lane_width-1:0] pick(input lane_word_t word, input logic bank);
    logic [lane_width-1:0] bits;
    for (int b = 0; b < lane_width; b++) begin
      bits[b] = word[2*b + bank];
    end
    return bits;
  endfunction

  assign wr_ben      = {lane_width{wr.bank, ~wr.bank}};
  assign entry_done  = wr_en && wr.bank;  // bank 1 write completes the entry.
  assign entry_ready = (count != '0);
  assign almost_full = (count >= entry_count_t'(almost_full_level));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({entry_done, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither.
      endcase
    end
  end

  for (genvar x = 0; x < lane_count; x++) begin : g_lane
    msi_data_ram u_ram (
      .clk     (clk),
      .rd_addr (rd_ptr),
      .rd_en   (rd_en),
      .rd_data (rd_word[x]),
      .wr_addr (wr.addr),
      .wr_data (spread(wr.data[x*lane_width +: lane_width])),
      .wr_ben  (wr_ben),
      .wr_en   (wr_en)
    );

    assign rd_line[x*lane_width +: lane_width] = pick(rd_word[x], rd_bank);
  end

  rd_needs_entry: assert property (
    @(posedge clk) disable iff (!arst_n)
    rd_en |-> (count != '0)
  ) else $error("store read with no complete entry");

  count_bounded: assert property (
    @(posedge clk) disable iff (!arst_n)
    count <= entry_count_t'(entry_count)
  ) else $error("entry count above buffer depth");

endmodule

// ==== hw/msi_line_rx.sv ====
`timescale 1ns/1ps

module msi_line_rx (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   in_req,
  input  msi_buf_pkg::line_t     in_line,
  output logic                   in_ack,
  input  logic                   almost_full,
  output msi_buf_pkg::store_wr_t wr,
  output logic                   wr_en
);
  import msi_buf_pkg::*;

  rx_state_t   state;
  logic        bank;
  entry_addr_t wr_ptr;
  logic        accept;

  // new request is taken only below the almost-full level.
  assign accept = (state == rx_idle) && in_req && !almost_full;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= rx_idle;
      in_ack <= 1'b0;
      wr_en  <= 1'b0;
      bank   <= 1'b0;
      wr_ptr <= '0;
    end else begin
      wr_en <= accept;  // one-cycle strobe.
      case (state)
        rx_idle: begin
          if (accept) begin
            in_ack <= 1'b1;
            bank   <= ~bank;
            if (bank) begin
              wr_ptr <= wr_ptr + 1'b1;  // bank 1 closes the entry.
            end
            state  <= rx_ack;
          end
        end
        rx_ack: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr <= '{addr: wr_ptr, bank: bank, data: in_line};
    end
  end

  in_line_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (in_req && !in_ack) ##1 (in_req && !in_ack) |-> $stable(in_line)
  ) else $error("in_line changed while waiting for in_ack");

endmodule

// ==== hw/msi_line_tx.sv ====
`timescale 1ns/1ps

module msi_line_tx (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               entry_ready,
  output logic               rd_en,
  output logic               rd_bank,
  input  msi_buf_pkg::line_t rd_line,
  output logic               out_req,
  output msi_buf_pkg::line_t out_line,
  input  logic               out_ack
);
  import msi_buf_pkg::*;

  tx_state_t state;
  logic      load_line;

  // bank 1 is selected while the first handshake winds down.
  assign rd_bank   = (state == tx_wait0);
  assign load_line = (state == tx_load0) || ((state == tx_wait0) && !out_ack);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= tx_idle;
      rd_en   <= 1'b0;
      out_req <= 1'b0;
    end else begin
      rd_en <= 1'b0;
      case (state)
        tx_idle: begin
          if (entry_ready) begin
            rd_en <= 1'b1;
            state <= tx_read;
          end
        end
        tx_read: state <= tx_load0;  // store latches its read pointer.
        tx_load0: begin
          out_req <= 1'b1;
          state   <= tx_send0;
        end
        tx_send0: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= tx_wait0;
          end
        end
        tx_wait0: begin
          if (!out_ack) begin
            out_req <= 1'b1;
            state   <= tx_send1;
          end
        end
        tx_send1: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= tx_wait1;
          end
        end
        tx_wait1: begin
          if (!out_ack) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load_line) begin
      out_line <= rd_line;
    end
  end

  req_held: assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_req && !out_ack) |=> out_req
  ) else $error("out_req dropped before out_ack");

endmodule

// ==== hw/msi_data_buf.sv ====
`timescale 1ns/1ps

module msi_data_buf (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_req,
  input  msi_buf_pkg::line_t in_line,
  output logic               in_ack,
  output logic               out_req,
  output msi_buf_pkg::line_t out_line,
  input  logic               out_ack
);
  import msi_buf_pkg::*;

  store_wr_t wr;
  logic      wr_en;
  logic      almost_full;
  logic      rd_en;
  logic      rd_bank;
  line_t     rd_line;
  logic      entry_ready;

  msi_line_rx u_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_req      (in_req),
    .in_line     (in_line),
    .in_ack      (in_ack),
    .almost_full (almost_full),
    .wr          (wr),
    .wr_en       (wr_en)
  );

  msi_line_store u_store (
    .clk         (clk),
    .arst_n      (arst_n),
    .wr          (wr),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .rd_bank     (rd_bank),
    .rd_line     (rd_line),
    .entry_ready (entry_ready),
    .almost_full (almost_full)
  );

  msi_line_tx u_tx (
    .clk         (clk),
    .arst_n      (arst_n),
    .entry_ready (entry_ready),
    .rd_en       (rd_en),
    .rd_bank     (rd_bank),
    .rd_line     (rd_line),
    .out_req     (out_req),
    .out_line    (out_line),
    .out_ack     (out_ack)
  );

endmodule

// ==== tests/tb_msi_data_buf.sv ====
`timescale 1ns/1ps

module tb_msi_data_buf;
  import msi_buf_pkg::*;

  localparam int total_lines = 114;  // lines sent over all tests.

  logic  clk;
  logic  arst_n;
  logic  in_req;
  line_t in_line;
  logic  in_ack;
  logic  out_req;
  line_t out_line;
  logic  out_ack;

  line_t ref_q[$];
  int    seed = 24619;
  int    value_errors = 0;
  int    other_errors = 0;

  msi_data_buf dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_req   (in_req),
    .in_line  (in_line),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_line (out_line),
    .out_ack  (out_ack)
  );

  always #10 clk = ~clk;

  function automatic line_t make_line();
    line_t l;
    for (int i = 0; i < lane_count; i++) begin
      l[i*lane_width +: lane_width] = $random(seed);
    end
    return l;
  endfunction

  task automatic offer_line(input line_t line);
    @(negedge clk);
    in_line = line;
    in_req  = 1'b1;
    ref_q.push_back(line);  // order of offer is the expected order out.
  endtask

  task automatic complete_line();
    while (!in_ack) @(negedge clk);
    in_req = 1'b0;
    while (in_ack) @(negedge clk);
  endtask

  task automatic send_line(input line_t line);
    offer_line(line);
    complete_line();
  endtask

  task automatic recv_line(input int ack_delay);
    line_t expected;
    while (!out_req) @(negedge clk);
    assert (ref_q.size() != 0) else begin
      other_errors++;
      $display("line received at %0t while none was outstanding", $time);
    end
    if (ref_q.size() != 0) begin
      expected = ref_q.pop_front();
      assert (out_line === expected) else begin
        value_errors++;
        $display("FAIL %0t out_line expected %h got %h", $time, expected, out_line);
      end
    end
    repeat (ack_delay) @(negedge clk);
    out_ack = 1'b1;
    while (out_req) @(negedge clk);
    out_ack = 1'b0;
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (!out_req) else begin
        value_errors++;
        $display("FAIL %0t out_req expected 0 got %b", $time, out_req);
      end
    end
  endtask

  task automatic idle_after_reset();
    assert (!in_ack) else begin
      value_errors++;
      $display("FAIL %0t in_ack expected 0 got %b", $time, in_ack);
    end
    assert (!out_req) else begin
      value_errors++;
      $display("FAIL %0t out_req expected 0 got %b", $time, out_req);
    end
    expect_quiet(20);
  endtask

  task automatic fast_pairs();
    fork
      for (int i = 0; i < 20; i++) send_line(make_line());
      for (int i = 0; i < 20; i++) recv_line(0);
    join
  endtask

  task automatic odd_line_held();
    send_line(make_line());
    expect_quiet(50);  // a lone bank 0 line waits for its partner.
    send_line(make_line());
    recv_line(0);
    recv_line(1);
  endtask

  // the sender holds one entry, so 50 lines are taken before back-pressure.
  task automatic back_pressure();
    for (int i = 0; i < 50; i++) send_line(make_line());
    offer_line(make_line());
    repeat (50) begin
      @(negedge clk);
      assert (!in_ack) else begin
        value_errors++;
        $display("FAIL %0t in_ack expected 0 got %b", $time, in_ack);
      end
    end
    fork
      begin
        complete_line();
        send_line(make_line());
      end
      for (int i = 0; i < 52; i++) recv_line(0);
    join
  endtask

  task automatic random_traffic();
    fork
      for (int i = 0; i < 40; i++) begin
        repeat ({$random(seed)} % 3) @(negedge clk);
        send_line(make_line());
      end
      for (int i = 0; i < 40; i++) recv_line({$random(seed)} % 5);
    join
    assert (ref_q.size() == 0) else begin
      other_errors++;
      $display("%0d lines sent but never received", ref_q.size());
    end
    expect_quiet(20);  // no duplicate lines after the last one.
  endtask

  initial begin
    repeat (200 * total_lines + 2000) @(posedge clk);
    $display("timeout: run did not finish in %0d cycles", 200 * total_lines + 2000);
    $display("sim failed");
    $finish;
  end

  initial begin
    clk     = 1'b0;
    arst_n  = 1'b0;
    in_req  = 1'b0;
    in_line = '0;
    out_ack = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    idle_after_reset();
    fast_pairs();
    odd_line_held();
    back_pressure();
    random_traffic();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/msi_buf_pkg.sv
hw/msi_data_ram.sv
hw/msi_line_store.sv
hw/msi_line_rx.sv
hw/msi_line_tx.sv
hw/msi_data_buf.sv
tests/tb_msi_data_buf.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_msi_data_buf -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "sim passed" sim.log; then
  exit 0
else
  exit 1
fi
